//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_harness
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Result: FAILED" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
+incdir+common
common/harness_pkg.sv
memory/boot_rom.sv
memory/dram_mem.sv
fabric/harness_xbar.sv
logic/debug_gate.sv
logic/harness_top.sv
testbench/harness_asserts.sv
testbench/tb_harness.sv

//--- common/harness_cfg.svh
`ifndef HARNESS_CFG_SVH
`define HARNESS_CFG_SVH

// ----------------------------------------------------------------------
// Bus widths
// ----------------------------------------------------------------------
`define HARNESS_ADDR_W      32
`define HARNESS_DATA_W      64
`define HARNESS_NB_HARTS    2

// ----------------------------------------------------------------------
// Address map
// ----------------------------------------------------------------------
`define HARNESS_ROM_BASE    32'h0001_0000
`define HARNESS_ROM_WORDS   32
`define HARNESS_DRAM_BASE   32'h8000_0000
`define HARNESS_DRAM_WORDS  512
`define HARNESS_GPIO_BASE   32'h4000_0000
`define HARNESS_GPIO_BYTES  32'h0000_1000   // Reserved, answers with an error

// Last DRAM word
`define HARNESS_EXIT_ADDR   (`HARNESS_DRAM_BASE + 32'((`HARNESS_DRAM_WORDS - 1) * 8))

`define HARNESS_ROM_TAG     32'hB007_B007   // Upper half of every ROM word
`define HARNESS_DBG_DELAY   50              // Cycles of debug masking after reset

`endif

//--- common/harness_pkg.sv
`include "harness_cfg.svh"

package harness_pkg;

  // ----------------------------------------------------------------------
  // Basic words
  // ----------------------------------------------------------------------
  typedef logic [`HARNESS_ADDR_W-1:0]   addr_t;
  typedef logic [`HARNESS_DATA_W-1:0]   data_t;
  typedef logic [`HARNESS_DATA_W/8-1:0] strb_t;
  typedef logic [`HARNESS_NB_HARTS-1:0] hart_vec_t;

  // Sized for the larger region
  typedef logic [$clog2(`HARNESS_DRAM_WORDS)-1:0] off_t;

  // ----------------------------------------------------------------------
  // Host side
  // ----------------------------------------------------------------------
  typedef struct packed {
    addr_t addr;
    logic  we;
    strb_t be;
    data_t wdata;
  } bus_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } bus_rsp_t;

  // ----------------------------------------------------------------------
  // Target side
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic  valid;    // One-cycle strobe
    logic  we;
    off_t  offset;   // Word offset within the region
    strb_t be;
    data_t wdata;
  } tgt_req_t;

  typedef enum logic [1:0] {
    TGT_ROM,
    TGT_DRAM,
    TGT_NONE
  } target_e;

endpackage

//--- fabric/harness_xbar.sv
`timescale 1ns/1ps
`include "harness_cfg.svh"

module harness_xbar (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_i,
  input  harness_pkg::bus_req_t req_data_i,
  output logic                  ack_o,
  output harness_pkg::bus_rsp_t rsp_o,
  output harness_pkg::tgt_req_t rom_req_o,
  input  harness_pkg::data_t    rom_rdata_i,
  output harness_pkg::tgt_req_t dram_req_o,
  input  harness_pkg::data_t    dram_rdata_i
);
  import harness_pkg::*;

  localparam int unsigned ByteOffW  = $clog2(`HARNESS_DATA_W / 8);
  localparam int unsigned OffW      = $bits(off_t);
  localparam addr_t       RomBytes  = addr_t'(`HARNESS_ROM_WORDS * (`HARNESS_DATA_W / 8));
  localparam addr_t       DramBytes = addr_t'(`HARNESS_DRAM_WORDS * (`HARNESS_DATA_W / 8));

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT,
    ACK
  } state_e;

  state_e   state_q;
  state_e   state_d;
  bus_req_t req_q;
  target_e  tgt_d;
  target_e  tgt_q;
  off_t     off_d;
  off_t     off_q;
  bus_rsp_t rsp_d;
  bus_rsp_t rsp_q;
  addr_t    rom_rel;
  addr_t    dram_rel;
  addr_t    gpio_rel;
  logic     rom_hit;
  logic     dram_hit;
  logic     gpio_hit;
  tgt_req_t strobe;

  // ----------------------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------------------
  // Offsets wrap below the base, so one unsigned compare per region
  assign rom_rel  = req_data_i.addr - addr_t'(`HARNESS_ROM_BASE);
  assign dram_rel = req_data_i.addr - addr_t'(`HARNESS_DRAM_BASE);
  assign gpio_rel = req_data_i.addr - addr_t'(`HARNESS_GPIO_BASE);
  assign rom_hit  = rom_rel < RomBytes;
  assign dram_hit = dram_rel < DramBytes;
  assign gpio_hit = gpio_rel < addr_t'(`HARNESS_GPIO_BYTES);

  always_comb begin
    tgt_d = TGT_NONE;
    off_d = '0;
    if (gpio_hit) begin
      tgt_d = TGT_NONE;                       // Error slave window
    end else if (rom_hit && !req_data_i.we) begin
      tgt_d = TGT_ROM;                        // ROM writes fall through to error
      off_d = rom_rel[ByteOffW +: OffW];
    end else if (dram_hit) begin
      tgt_d = TGT_DRAM;
      off_d = dram_rel[ByteOffW +: OffW];
    end
  end

  // ----------------------------------------------------------------------
  // Four-phase slave FSM
  // ----------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    rsp_d   = rsp_q;
    case (state_q)
      IDLE: begin
        if (req_i) begin
          state_d = ISSUE;
        end
      end
      ISSUE: state_d = WAIT;                  // Target strobed this cycle
      WAIT: begin
        state_d   = ACK;
        rsp_d.err = (tgt_q == TGT_NONE);
        case (tgt_q)
          TGT_ROM:  rsp_d.rdata = rom_rdata_i;
          TGT_DRAM: rsp_d.rdata = req_q.we ? '0 : dram_rdata_i;
          default:  rsp_d.rdata = '0;
        endcase
      end
      ACK: begin
        if (!req_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      tgt_q   <= TGT_NONE;
      rsp_q   <= '0;
    end else begin
      state_q <= state_d;
      rsp_q   <= rsp_d;
      if (state_q == IDLE && req_i) begin
        tgt_q <= tgt_d;
      end
    end
  end

  // Request payload and offset, held for the whole exchange
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && req_i) begin
      req_q <= req_data_i;
      off_q <= off_d;
    end
  end

  // ----------------------------------------------------------------------
  // Target strobes
  // ----------------------------------------------------------------------
  assign strobe.valid  = (state_q == ISSUE);
  assign strobe.we     = req_q.we;
  assign strobe.offset = off_q;
  assign strobe.be     = req_q.be;
  assign strobe.wdata  = req_q.wdata;

  always_comb begin
    rom_req_o        = strobe;
    rom_req_o.valid  = strobe.valid && (tgt_q == TGT_ROM);
    dram_req_o       = strobe;
    dram_req_o.valid = strobe.valid && (tgt_q == TGT_DRAM);
  end

  assign ack_o = (state_q == ACK);
  assign rsp_o = rsp_q;

endmodule

//--- logic/debug_gate.sv
`timescale 1ns/1ps
`include "harness_cfg.svh"

module debug_gate (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   debug_en_i,
  input  harness_pkg::hart_vec_t debug_req_i,
  output harness_pkg::hart_vec_t debug_req_o
);

  localparam int unsigned CntW = $clog2(`HARNESS_DBG_DELAY + 1);

  logic [CntW-1:0] cnt_q;
  logic            blocked;

  // Post-reset window, saturates at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= CntW'(`HARNESS_DBG_DELAY);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign blocked     = (cnt_q != '0) || !debug_en_i;
  assign debug_req_o = blocked ? '0 : debug_req_i;   // Per-hart mask

endmodule

//--- logic/harness_top.sv
`timescale 1ns/1ps
`include "harness_cfg.svh"

module harness_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_i,
  input  harness_pkg::bus_req_t  req_data_i,
  output logic                   ack_o,
  output harness_pkg::bus_rsp_t  rsp_o,
  output harness_pkg::data_t     exit_o,
  input  logic                   debug_en_i,
  input  harness_pkg::hart_vec_t debug_req_i,
  output harness_pkg::hart_vec_t debug_req_o
);
  import harness_pkg::*;

  tgt_req_t rom_req;
  tgt_req_t dram_req;
  data_t    rom_rdata;
  data_t    dram_rdata;

  // ----------------------------------------------------------------------
  // Fabric and targets
  // ----------------------------------------------------------------------
  harness_xbar u_xbar (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .req_i        ( req_i      ),
    .req_data_i   ( req_data_i ),
    .ack_o        ( ack_o      ),
    .rsp_o        ( rsp_o      ),
    .rom_req_o    ( rom_req    ),
    .rom_rdata_i  ( rom_rdata  ),
    .dram_req_o   ( dram_req   ),
    .dram_rdata_i ( dram_rdata )
  );

  boot_rom u_rom (
    .clk_i   ( clk_i     ),
    .req_i   ( rom_req   ),
    .rdata_o ( rom_rdata )
  );

  dram_mem u_dram (
    .clk_i   ( clk_i      ),
    .rst_ni  ( rst_ni     ),
    .req_i   ( dram_req   ),
    .rdata_o ( dram_rdata ),
    .exit_o  ( exit_o     )   // Simulation exit code
  );

  // ----------------------------------------------------------------------
  // Debug request gating
  // ----------------------------------------------------------------------
  debug_gate u_dbg (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .debug_en_i  ( debug_en_i  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

//--- memory/boot_rom.sv
`timescale 1ns/1ps
`include "harness_cfg.svh"

module boot_rom (
  input  logic                  clk_i,
  input  harness_pkg::tgt_req_t req_i,
  output harness_pkg::data_t    rdata_o
);

  localparam int unsigned IdxW  = $clog2(`HARNESS_ROM_WORDS);
  localparam int unsigned HalfW = `HARNESS_DATA_W / 2;

  logic [`HARNESS_DATA_W-1:0] rom_tbl [`HARNESS_ROM_WORDS];

  // ----------------------------------------------------------------------
  // Table contents, tag over word index
  // ----------------------------------------------------------------------
  for (genvar i = 0; i < `HARNESS_ROM_WORDS; i++) begin : gen_rom_word
    assign rom_tbl[i] = {HalfW'(`HARNESS_ROM_TAG), HalfW'(i)};
  end

  // Registered read, decoder keeps offset in range
  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      rdata_o <= rom_tbl[req_i.offset[IdxW-1:0]];
    end
  end

endmodule

//--- memory/dram_mem.sv
`timescale 1ns/1ps
`include "harness_cfg.svh"

module dram_mem (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  harness_pkg::tgt_req_t req_i,
  output harness_pkg::data_t    rdata_o,
  output harness_pkg::data_t    exit_o
);
  import harness_pkg::*;

  localparam int unsigned NumBytes = `HARNESS_DATA_W / 8;
  localparam off_t        ExitOff  =
      off_t'((`HARNESS_EXIT_ADDR - `HARNESS_DRAM_BASE) / NumBytes);

  data_t mem_q [`HARNESS_DRAM_WORDS];
  data_t exit_q;
  logic  exit_wr;

  // ----------------------------------------------------------------------
  // Word array
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      if (req_i.we) begin
        for (int unsigned b = 0; b < NumBytes; b++) begin
          if (req_i.be[b]) begin
            mem_q[req_i.offset][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end
      rdata_o <= mem_q[req_i.offset];   // Old word on a write, fabric drops it
    end
  end

  // ----------------------------------------------------------------------
  // Exit register
  // ----------------------------------------------------------------------
  // Takes the full word, byte enables do not apply here
  assign exit_wr = req_i.valid && req_i.we && (req_i.offset == ExitOff);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exit_q <= '0;
    end else if (exit_wr) begin
      exit_q <= req_i.wdata;
    end
  end

  assign exit_o = exit_q;

endmodule

//--- testbench/harness_asserts.sv
`timescale 1ns/1ps
`include "harness_cfg.svh"

module harness_asserts (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   req_i,
  input logic                   ack_i,
  input harness_pkg::bus_rsp_t  rsp_i,
  input harness_pkg::hart_vec_t gated_req_i
);

  localparam int unsigned CntW = $clog2(`HARNESS_DBG_DELAY + 1);

  logic [CntW-1:0] since_rst_q;   // Mirrors the gate window
  int unsigned     fail_cnt = 0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      since_rst_q <= '0;
    end else if (since_rst_q != CntW'(`HARNESS_DBG_DELAY)) begin
      since_rst_q <= since_rst_q + CntW'(1);
    end
  end

  // ----------------------------------------------------------------------
  // Handshake
  // ----------------------------------------------------------------------
  ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $rose(ack_i) |-> req_i)
    else begin
      fail_cnt++;
      $error("ack_o rose while req_i was low");
    end

  rsp_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (ack_i && $past(ack_i)) |-> $stable(rsp_i))
    else begin
      fail_cnt++;
      $error("rsp_o changed while ack_o was high");
    end

  // Debug requests masked during the post-reset window
  gate_window: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (since_rst_q < CntW'(`HARNESS_DBG_DELAY)) |-> (gated_req_i == '0))
    else begin
      fail_cnt++;
      $error("debug_req_o active inside the post-reset window");
    end

endmodule

bind harness_top harness_asserts u_asserts (
  .clk_i       ( clk_i       ),
  .rst_ni      ( rst_ni      ),
  .req_i       ( req_i       ),
  .ack_i       ( ack_o       ),
  .rsp_i       ( rsp_o       ),
  .gated_req_i ( debug_req_o )
);

//--- testbench/tb_harness.sv
`timescale 1ns/1ps
`include "harness_cfg.svh"

module tb_harness;
  import harness_pkg::*;

  localparam int unsigned ResetCycles  = 10;
  localparam int unsigned AckLimit     = 200;
  localparam int unsigned HoldCycles   = 2;   // Extra cycles req stays high after ack
  localparam int unsigned NumDramWords = 8;
  // ROM sweep, error cases, DRAM fill/update/read-back, exit pair
  localparam int unsigned NumAccesses  = `HARNESS_ROM_WORDS + 4 + 3 * NumDramWords + 2;
  localparam int unsigned WatchdogCycles =
      ResetCycles + `HARNESS_DBG_DELAY + 20 + NumAccesses * AckLimit;

  logic        clk;
  logic        rst_n;
  logic        req;
  bus_req_t    req_data;
  logic        ack;
  bus_rsp_t    rsp;
  data_t       exit_val;
  logic        debug_en;
  hart_vec_t   debug_req_in;
  hart_vec_t   debug_req_out;
  logic [31:0] lcg_state;
  data_t       dram_model [`HARNESS_DRAM_WORDS];

  harness_top u_dut (
    .clk_i       ( clk           ),
    .rst_ni      ( rst_n         ),
    .req_i       ( req           ),
    .req_data_i  ( req_data      ),
    .ack_o       ( ack           ),
    .rsp_o       ( rsp           ),
    .exit_o      ( exit_val      ),
    .debug_en_i  ( debug_en      ),
    .debug_req_i ( debug_req_in  ),
    .debug_req_o ( debug_req_out )
  );

  always #5 clk = ~clk;

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic data_t lcg_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi, lo};
  endfunction

  // Byte-enable merge as the bus defines it
  function automatic data_t merge_bytes(input data_t old_word, input data_t wdata,
                                        input strb_t be);
    data_t result;
    result = old_word;
    for (int b = 0; b < $bits(strb_t); b++) begin
      if (be[b]) result[8*b +: 8] = wdata[8*b +: 8];
    end
    return result;
  endfunction

  function automatic bus_rsp_t make_rsp(input data_t rdata, input logic err);
    bus_rsp_t r;
    r.rdata = rdata;
    r.err   = err;
    return r;
  endfunction

  function automatic addr_t dram_addr(input off_t off);
    return addr_t'(`HARNESS_DRAM_BASE) + (addr_t'(off) << 3);
  endfunction

  task automatic stop_failed();
    $display("Result: FAILED");
    $fatal(1, "Run stopped on the first error");
  endtask

  task automatic check_rsp(input string name, input bus_rsp_t exp, input bus_rsp_t act);
    if (act !== exp) begin
      $display("Fail t=%0t %s expected rdata=%h err=%b actual rdata=%h err=%b",
               $time, name, exp.rdata, exp.err, act.rdata, act.err);
      stop_failed();
    end
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("Fail t=%0t %s expected %h actual %h", $time, name, exp, act);
      stop_failed();
    end
  endtask

  task automatic check_harts(input string name, input hart_vec_t exp, input hart_vec_t act);
    if (act !== exp) begin
      $display("Fail t=%0t %s expected %b actual %b", $time, name, exp, act);
      stop_failed();
    end
  endtask

  // Full four-phase exchange with the response sampled on the falling edge
  task automatic bus_access(input addr_t addr, input logic we, input strb_t be,
                            input data_t wdata, output bus_rsp_t rsp_out);
    int unsigned waited;
    @(negedge clk);
    req_data.addr  = addr;
    req_data.we    = we;
    req_data.be    = be;
    req_data.wdata = wdata;
    req            = 1'b1;
    waited         = 0;
    while (ack !== 1'b1) begin
      @(negedge clk);
      waited++;
      if (waited > AckLimit) begin
        $display("Timeout: no ack for the access to address %h", addr);
        stop_failed();
      end
    end
    if (waited < 2) begin
      $display("Ack came less than two cycles after the request to %h", addr);
      stop_failed();
    end
    rsp_out = rsp;
    // Back-pressure, ack and response must hold while req stays high
    repeat (HoldCycles) begin
      @(negedge clk);
      if (ack !== 1'b1) begin
        $display("Ack dropped while the request to %h was still high", addr);
        stop_failed();
      end
      check_rsp("rsp_o", rsp_out, rsp);
    end
    req     = 1'b0;
    waited  = 0;
    while (ack !== 1'b0) begin
      @(negedge clk);
      waited++;
      if (waited > 2) begin
        $display("Ack stayed high more than two cycles after the request dropped");
        stop_failed();
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------------------
  task automatic debug_gating_test();
    for (int k = 1; k <= `HARNESS_DBG_DELAY - 5; k++) begin
      @(negedge clk);
      check_harts("debug_req_o", '0, debug_req_out);
    end
    repeat (10) @(negedge clk);   // Now DELAY+5 cycles after release
    check_harts("debug_req_o", debug_req_in, debug_req_out);
    debug_en = 1'b0;
    @(negedge clk);
    check_harts("debug_req_o", '0, debug_req_out);
    debug_en = 1'b1;
  endtask

  task automatic rom_read_test();
    bus_rsp_t r;
    for (int i = 0; i < `HARNESS_ROM_WORDS; i++) begin
      bus_access(addr_t'(`HARNESS_ROM_BASE) + addr_t'(i * 8), 1'b0, '0, '0, r);
      check_rsp("rsp_o", make_rsp({32'(`HARNESS_ROM_TAG), 32'(i)}, 1'b0), r);
    end
  endtask

  task automatic dram_merge_test();
    off_t     offs [NumDramWords];
    bus_rsp_t r;
    data_t    wdata;
    strb_t    be;
    for (int i = 0; i < NumDramWords; i++) begin   // Full-word fill that skips the exit word
      offs[i] = off_t'(lcg_next() % (`HARNESS_DRAM_WORDS - 1));
      wdata   = lcg_word();
      dram_model[offs[i]] = wdata;
      bus_access(dram_addr(offs[i]), 1'b1, '1, wdata, r);
      check_rsp("rsp_o", make_rsp('0, 1'b0), r);
    end
    for (int i = 0; i < NumDramWords; i++) begin
      wdata = lcg_word();
      be    = strb_t'(lcg_next());
      dram_model[offs[i]] = merge_bytes(dram_model[offs[i]], wdata, be);
      bus_access(dram_addr(offs[i]), 1'b1, be, wdata, r);
      check_rsp("rsp_o", make_rsp('0, 1'b0), r);
    end
    for (int i = 0; i < NumDramWords; i++) begin
      bus_access(dram_addr(offs[i]), 1'b0, '0, '0, r);
      check_rsp("rsp_o", make_rsp(dram_model[offs[i]], 1'b0), r);
    end
  endtask

  task automatic error_resp_test();
    bus_rsp_t r;
    bus_access(32'h2000_0000, 1'b0, '0, '0, r);              // Unmapped
    check_rsp("rsp_o", make_rsp('0, 1'b1), r);
    bus_access(addr_t'(`HARNESS_GPIO_BASE) + 32'h10, 1'b0, '0, '0, r);
    check_rsp("rsp_o", make_rsp('0, 1'b1), r);
    bus_access(addr_t'(`HARNESS_GPIO_BASE), 1'b1, '1, lcg_word(), r);
    check_rsp("rsp_o", make_rsp('0, 1'b1), r);
    bus_access(addr_t'(`HARNESS_ROM_BASE) + 32'h8, 1'b1, '1, lcg_word(), r);
    check_rsp("rsp_o", make_rsp('0, 1'b1), r);
  endtask

  task automatic exit_reg_test();
    bus_rsp_t r;
    data_t    wdata;
    strb_t    be;
    bus_access(dram_addr(off_t'(3)), 1'b1, '1, lcg_word(), r);
    check_data("exit_o", '0, exit_val);   // Still the reset value
    wdata = lcg_word();
    be    = strb_t'(lcg_next());
    bus_access(`HARNESS_EXIT_ADDR, 1'b1, be, wdata, r);
    check_rsp("rsp_o", make_rsp('0, 1'b0), r);
    check_data("exit_o", wdata, exit_val);
  endtask

  // ----------------------------------------------------------------------
  // Main sequence and watchdog
  // ----------------------------------------------------------------------
  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    req          = 1'b0;
    req_data     = '0;
    debug_en     = 1'b1;
    debug_req_in = '1;
    lcg_state    = 32'h8f1c06d8;
    repeat (ResetCycles) @(negedge clk);
    if (ack !== 1'b0) begin
      $display("ack_o is not low during reset");
      stop_failed();
    end
    check_rsp("rsp_o", make_rsp('0, 1'b0), rsp);
    check_data("exit_o", '0, exit_val);
    check_harts("debug_req_o", '0, debug_req_out);
    rst_n = 1'b1;
    debug_gating_test();
    rom_read_test();
    dram_merge_test();
    error_resp_test();
    exit_reg_test();
    if (u_dut.u_asserts.fail_cnt != 0) begin
      $display("Assertion failures were reported during the run");
      stop_failed();
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", WatchdogCycles);
    stop_failed();
  end

endmodule
